// File: rtl/fifo_aurora_pkg.sv
package fifo_aurora_pkg;

    //////////////////////////////
    // Packet and stream geometry
    //////////////////////////////

    localparam int PACKET_BITS      = 256;                       // One FIFO entry
    localparam int WORD_BITS        = 32;                        // One lane of the link
    localparam int WORDS_PER_PACKET = PACKET_BITS / WORD_BITS;   // Eight words per packet
    localparam int HEADER_WORDS     = 2;                         // Header goes out ahead of data
    localparam int MAX_PAYLOAD_WORDS = WORDS_PER_PACKET - HEADER_WORDS;

    // Number of consecutive high samples of channel_up before the link counts as stable
    localparam int LINK_STABLE_CYCLES = 4;

    //////////////////////////////
    // Header field positions
    //////////////////////////////

    localparam int SEQ_BYTE_MSB    = 255;   // Bus id on the FIFO side, sequence number on the link
    localparam int SRC_ID_MSB      = 247;   // FPGA that created the packet
    localparam int VALID_BYTES_MSB = 207;
    localparam int VALID_BYTES_LSB = 192;

    // The two low bits of the byte count are always zero for whole words
    localparam int BYTES_PER_WORD_LOG2 = $clog2(WORD_BITS / 8);
    localparam int WORD_COUNT_BITS =
        VALID_BYTES_MSB - VALID_BYTES_LSB + 1 - BYTES_PER_WORD_LOG2;

    //////////////////////////////
    // Shared types
    //////////////////////////////

    typedef logic [PACKET_BITS-1:0]     packet_t;
    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [7:0]                 fpga_id_t;
    typedef logic [7:0]                 seq_t;
    typedef logic [WORD_COUNT_BITS-1:0] word_count_t;

    // Index of a word inside one packet, wide enough for every word of a frame
    typedef logic [$clog2(WORDS_PER_PACKET)-1:0] word_index_t;

    // Packets born at the far end must not be sent back to it
    localparam fpga_id_t TARGET_FPGA_ID = 8'h01;

endpackage

// File: rtl/link_up_filter.sv
`timescale 1ns/1ps

module link_up_filter (
    input  logic user_clk,
    input  logic reset_TX_RX_Block,
    input  logic channel_up,
    output logic link_up
);

    import fifo_aurora_pkg::*;

    // Last LINK_STABLE_CYCLES samples of channel_up, newest in bit 0
    logic [LINK_STABLE_CYCLES-1:0] history;

    //////////////////////////////
    // Sample history
    //////////////////////////////

    // During lane training channel_up can rise and drop again after a few cycles
    // Only a run of high samples long enough to fill the history is trusted
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            history <= '0;                                          // Link counts as down
        end else begin
            history <= {history[LINK_STABLE_CYCLES-2:0], channel_up}; // Shift in newest sample
        end
    end

    // Every stored sample must be high
    // A single low sample clears the indication on the next edge
    assign link_up = &history;

endmodule

// File: rtl/packet_shifter.sv
`timescale 1ns/1ps

module packet_shifter (
    input  logic                         user_clk,
    input  logic                         reset_TX_RX_Block,
    input  fifo_aurora_pkg::packet_t     packet,
    input  logic                         load,
    input  logic                         shift,
    input  logic                         frame_done,
    output fifo_aurora_pkg::fpga_id_t    src_id,
    output fifo_aurora_pkg::word_count_t word_count,
    output fifo_aurora_pkg::word_t       word
);

    import fifo_aurora_pkg::*;

    // Bit position of the sequence byte inside the top word of the packet
    localparam int SEQ_POS_MSB = SEQ_BYTE_MSB - (PACKET_BITS - WORD_BITS);

    packet_t pkt_q;        // Packet being framed, current word on top
    logic    at_header;    // Header word 0 is still on top
    seq_t    seq_cnt;      // Frame sequence number for the receiver
    word_t   top_word;

    //////////////////////////////
    // Packet register
    //////////////////////////////

    // Load wins over shift, the controller never asks for both in one cycle
    always_ff @(posedge user_clk) begin
        if (load) begin
            pkt_q <= packet;                                           // Capture FIFO head
        end else if (shift) begin
            pkt_q <= {pkt_q[PACKET_BITS-WORD_BITS-1:0], {WORD_BITS{1'b0}}}; // Next word up
        end
    end

    // Header fields are kept apart from the shifting packet
    // The controller reads them in CHECK and through the whole frame
    always_ff @(posedge user_clk) begin
        if (load) begin
            src_id     <= packet[SRC_ID_MSB -: $bits(fpga_id_t)];
            word_count <= packet[VALID_BYTES_MSB : VALID_BYTES_LSB + BYTES_PER_WORD_LOG2];
        end
    end

    // Marks that the first header word is on top and needs its bus id replaced
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            at_header <= 1'b0;
        end else if (load) begin
            at_header <= 1'b1;      // Fresh packet starts with header word 0
        end else if (shift) begin
            at_header <= 1'b0;      // Word 0 has left, rest goes out unchanged
        end
    end

    //////////////////////////////
    // Sequence counter
    //////////////////////////////

    // Counts frames that actually went out, dropped packets leave it alone
    // The receiver expects 0, 1, 2 and so on, wrapping after 255
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            seq_cnt <= '0;
        end else if (frame_done) begin
            seq_cnt <= seq_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Word output
    //////////////////////////////

    assign top_word = pkt_q[PACKET_BITS-1 -: WORD_BITS];

    // The bus id only matters inside one FPGA, on the link its byte carries the sequence
    always_comb begin
        word = top_word;
        if (at_header) begin
            word[SEQ_POS_MSB -: $bits(seq_t)] = seq_cnt;   // Replace bus id
        end
    end

endmodule

// File: rtl/tx_frame_ctrl.sv
`timescale 1ns/1ps

module tx_frame_ctrl (
    input  logic                         user_clk,
    input  logic                         reset_TX_RX_Block,
    input  logic                         empty,
    input  logic                         link_up,
    input  logic                         accept,
    input  fifo_aurora_pkg::fpga_id_t    src_id,
    input  fifo_aurora_pkg::word_count_t word_count,
    output logic                         rd_en,
    output logic                         load,
    output logic                         shift,
    output logic                         frame_done,
    output logic                         word_valid,
    output logic                         word_last
);

    import fifo_aurora_pkg::*;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // Wait for a packet and a stable link
        LOAD  = 2'd1,   // Pop the FIFO and capture the head packet
        CHECK = 2'd2,   // Decide between send and drop
        SEND  = 2'd3    // Stream header and payload words
    } state_t;

    state_t      state;
    state_t      next_state;
    word_index_t word_cnt;      // Words already handed to the output register
    word_count_t last_index;    // Index of the final word of this frame
    logic        drop;

    //////////////////////////////
    // Packet checks
    //////////////////////////////

    // Broadcast loop prevention and sanity of the length field
    assign drop = (src_id == TARGET_FPGA_ID)
               || (word_count == '0)
               || (word_count > word_count_t'(MAX_PAYLOAD_WORDS));

    // Header words plus payload words, minus one for a zero based index
    assign last_index = word_count_t'(HEADER_WORDS) + word_count - word_count_t'(1);

    //////////////////////////////
    // State register
    //////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // link_up is only looked at here in IDLE so a frame that has started always ends
    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (!empty && link_up) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                next_state = CHECK;   // Header fields are valid one cycle after the capture
            end
            CHECK: begin
                if (drop) begin
                    next_state = IDLE;  // Packet already popped, nothing goes out
                end else begin
                    next_state = SEND;
                end
            end
            SEND: begin
                if (accept && word_last) begin
                    next_state = IDLE;  // Final word taken by the output register
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    //////////////////////////////
    // Word counter
    //////////////////////////////

    // Advances only when the output register takes a word, so back-pressure freezes it
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            word_cnt <= '0;
        end else if (state != SEND) begin
            word_cnt <= '0;                 // Ready for the next frame
        end else if (accept) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign rd_en      = (state == LOAD);   // One cycle pop of the fall-through FIFO
    assign load       = (state == LOAD);   // Capture happens on the same edge as the pop
    assign word_valid = (state == SEND);
    assign word_last  = word_valid && (word_count_t'(word_cnt) == last_index);
    assign shift      = word_valid && accept;   // Next word moves up once this one is taken
    assign frame_done = shift && word_last;      // Only sent frames bump the sequence

endmodule

// File: rtl/stream_out_reg.sv
`timescale 1ns/1ps

module stream_out_reg (
    input  logic                   user_clk,
    input  logic                   reset_TX_RX_Block,
    input  fifo_aurora_pkg::word_t word,
    input  logic                   word_valid,
    input  logic                   word_last,
    input  logic                   s_axi_tx_tready,
    output logic                   accept,
    output fifo_aurora_pkg::word_t s_axi_tx_tdata,
    output logic                   s_axi_tx_tvalid,
    output logic                   s_axi_tx_tlast
);

    // Room for a new word when the register is empty or its word leaves this cycle
    assign accept = !s_axi_tx_tvalid || s_axi_tx_tready;

    //////////////////////////////
    // Stream control flags
    //////////////////////////////

    // While accept is low everything holds, so the link sees a steady word under stall
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            s_axi_tx_tvalid <= 1'b0;
            s_axi_tx_tlast  <= 1'b0;
        end else if (accept) begin
            s_axi_tx_tvalid <= word_valid;                // Drops after a transfer with no new word
            s_axi_tx_tlast  <= word_valid && word_last;
        end
    end

    //////////////////////////////
    // Stream data
    //////////////////////////////

    always_ff @(posedge user_clk) begin
        if (accept && word_valid) begin
            s_axi_tx_tdata <= word;   // Only a real word replaces the held one
        end
    end

endmodule

// File: rtl/fifo_to_aurora_tx.sv
`timescale 1ns/1ps

module fifo_to_aurora_tx (
    input  logic                     user_clk,
    input  logic                     reset_TX_RX_Block,
    input  logic                     empty,
    input  fifo_aurora_pkg::packet_t dout,
    output logic                     rd_en,
    input  logic                     channel_up,
    input  logic                     s_axi_tx_tready,
    output fifo_aurora_pkg::word_t   s_axi_tx_tdata,
    output logic                     s_axi_tx_tvalid,
    output logic                     s_axi_tx_tlast
);

    import fifo_aurora_pkg::*;

    logic        link_up;       // Debounced channel_up
    logic        load;          // Capture the FIFO head
    logic        shift;         // Move the next word to the top
    logic        frame_done;    // A frame left completely
    logic        word_valid;
    logic        word_last;
    logic        accept;        // Output register can take a word
    fpga_id_t    src_id;
    word_count_t word_count;
    word_t       word;

    //////////////////////////////
    // Link qualification
    //////////////////////////////

    link_up_filter u_link_up_filter (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .channel_up        (channel_up),
        .link_up           (link_up)
    );

    //////////////////////////////
    // Framing control
    //////////////////////////////

    tx_frame_ctrl u_tx_frame_ctrl (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .link_up           (link_up),
        .accept            (accept),
        .src_id            (src_id),
        .word_count        (word_count),
        .rd_en             (rd_en),
        .load              (load),
        .shift             (shift),
        .frame_done        (frame_done),
        .word_valid        (word_valid),
        .word_last         (word_last)
    );

    // Holds the popped packet and puts the sequence number into the header
    packet_shifter u_packet_shifter (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .packet            (dout),
        .load              (load),
        .shift             (shift),
        .frame_done        (frame_done),
        .src_id            (src_id),
        .word_count        (word_count),
        .word              (word)
    );

    //////////////////////////////
    // Link side register
    //////////////////////////////

    stream_out_reg u_stream_out_reg (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .word              (word),
        .word_valid        (word_valid),
        .word_last         (word_last),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .accept            (accept),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast)
    );

endmodule

// File: test/tb_fifo_to_aurora_tx.sv
`timescale 1ns/1ps

module tb_fifo_to_aurora_tx;

    import fifo_aurora_pkg::*;

    localparam int CLK_HALF_NS  = 20;     // 40 ns period
    localparam int RESET_CYCLES = 8;
    localparam int ROWS         = 10;     // Packets in the stimulus table
    localparam int PASSES       = 2;      // Free running link first, then random back-pressure
    localparam int STALL_FACTOR = 4;      // tready is low about one cycle in four
    localparam int PATTERN_LEN  = 256;
    // Longest frame plus the IDLE, LOAD and CHECK cycles around it
    localparam int WORST_FRAME_CYCLES = WORDS_PER_PACKET + 3;
    localparam int TIMEOUT_CYCLES = ROWS * PASSES * WORST_FRAME_CYCLES * STALL_FACTOR + 200;

    logic    user_clk;
    logic    reset_TX_RX_Block;
    logic    empty;
    packet_t dout;
    logic    rd_en;
    logic    channel_up;
    logic    s_axi_tx_tready;
    word_t   s_axi_tx_tdata;
    logic    s_axi_tx_tvalid;
    logic    s_axi_tx_tlast;

    // Stimulus table, one row per packet
    fpga_id_t row_src   [ROWS];
    int       row_count [ROWS];   // Payload words announced in the header
    word_t    row_seed  [ROWS];   // Base value of the payload words
    bit       row_send  [ROWS];   // Packet has to reach the link

    packet_t     fifo_q[$];       // FIFO model with the head at index 0
    word_t       exp_data_q[$];   // Scoreboard of words still to arrive
    bit          exp_last_q[$];
    word_t       exp_data;
    bit          exp_last;
    seq_t        exp_seq;         // Sequence number of the next sent frame
    int          pop_count;
    int          cycle_count;
    int          pattern_idx;
    bit          ready_pattern [PATTERN_LEN];
    bit          random_stall;
    logic        prev_stalled;    // Last edge saw tvalid high and tready low
    word_t       prev_data;
    logic        prev_last;
    int unsigned seed_value;

    fifo_to_aurora_tx dut (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .dout              (dout),
        .rd_en             (rd_en),
        .channel_up        (channel_up),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast)
    );

    always #CLK_HALF_NS user_clk = ~user_clk;

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            report_failure("Check of a DUT output failed");
        end
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    task automatic set_row(input int i, input fpga_id_t src, input int count,
                           input word_t seed, input bit send);
        row_src[i]   = src;
        row_count[i] = count;
        row_seed[i]  = seed;
        row_send[i]  = send;
    endtask

    task automatic fill_table();
        set_row(0, 8'h02,   6, 32'h1000_0001, 1'b1);   // Full payload
        set_row(1, 8'h01,   3, 32'h2000_0002, 1'b0);   // Came from the far end and must not loop back
        set_row(2, 8'h03,   1, 32'h3000_0003, 1'b1);   // Shortest frame
        set_row(3, 8'h04,   0, 32'h4000_0004, 1'b0);   // Empty payload
        set_row(4, 8'h05,   7, 32'h5000_0005, 1'b0);   // One word too many
        set_row(5, 8'h06,   4, 32'h6000_0006, 1'b1);
        set_row(6, 8'h07, 200, 32'h7000_0007, 1'b0);   // Far beyond the packet
        set_row(7, 8'h00,   2, 32'h8000_0008, 1'b1);
        set_row(8, 8'h02,   5, 32'h9000_0009, 1'b1);
        set_row(9, 8'h08,   6, 32'ha000_000a, 1'b1);
    endtask

    // Header word 0 holds bus id and source id and word 1 holds the valid-byte count
    function automatic packet_t build_packet(input int row);
        packet_t pkt;
        pkt = '0;
        pkt[SEQ_BYTE_MSB -: 8]          = 8'($urandom);   // Bus id, never seen on the link
        pkt[SRC_ID_MSB -: 8]            = row_src[row];
        pkt[SRC_ID_MSB - 8 -: 16]       = 16'($urandom);
        pkt[PACKET_BITS - WORD_BITS - 1 -: 16] = 16'($urandom);
        pkt[VALID_BYTES_MSB : VALID_BYTES_LSB] = 16'(row_count[row] * 4);
        for (int k = HEADER_WORDS; k < WORDS_PER_PACKET; k++) begin
            pkt[PACKET_BITS - 1 - k * WORD_BITS -: WORD_BITS] =
                row_seed[row] + word_t'(k * 32'h0101_0101);
        end
        return pkt;
    endfunction

    // Queues the packet in the FIFO model and predicts its frame
    task automatic push_row(input int row);
        packet_t pkt;
        word_t   w;
        int      frame_len;
        pkt       = build_packet(row);
        frame_len = HEADER_WORDS + row_count[row];
        fifo_q.push_back(pkt);
        if (row_send[row]) begin
            for (int k = 0; k < frame_len; k++) begin
                w = pkt[PACKET_BITS - 1 - k * WORD_BITS -: WORD_BITS];
                if (k == 0) begin
                    w[WORD_BITS - 1 -: 8] = exp_seq;   // Receiver sees the sequence number
                end
                exp_data_q.push_back(w);
                exp_last_q.push_back(k == frame_len - 1);
            end
            exp_seq = exp_seq + 1'b1;   // Dropped packets do not count
        end
    endtask

    task automatic wait_for_drain(input int pops_expected);
        while (pop_count < pops_expected || exp_data_q.size() != 0) begin
            @(negedge user_clk);
        end
    endtask

    //////////////////////////////
    // FIFO, link and checkers
    //////////////////////////////

    // First-word-fall-through FIFO model that shows the head on dout while empty is low
    always @(posedge user_clk) begin
        if (rd_en) begin
            if (fifo_q.size() == 0) begin
                report_failure("The DUT popped the FIFO while it was empty");
            end else begin
                fifo_q.delete(0);
                pop_count = pop_count + 1;
            end
        end
        empty <= (fifo_q.size() == 0);
        if (fifo_q.size() != 0) begin
            dout <= fifo_q[0];
        end
    end

    always @(posedge user_clk) begin
        s_axi_tx_tready <= random_stall ? ready_pattern[pattern_idx] : 1'b1;
        pattern_idx = (pattern_idx + 1) % PATTERN_LEN;
    end

    // DUT outputs and tready still show the values from before this edge
    always @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            prev_stalled = 1'b0;
        end else begin
            if (prev_stalled) begin   // A stalled word must stay on the bus
                check_value("s_axi_tx_tvalid", s_axi_tx_tvalid, 1'b1);
                check_value("s_axi_tx_tdata", s_axi_tx_tdata, prev_data);
                check_value("s_axi_tx_tlast", s_axi_tx_tlast, prev_last);
            end
            if (s_axi_tx_tvalid && s_axi_tx_tready) begin
                if (exp_data_q.size() == 0) begin
                    report_failure("A word was sent on the link while no frame was expected");
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    check_value("s_axi_tx_tdata", s_axi_tx_tdata, exp_data);
                    check_value("s_axi_tx_tlast", s_axi_tx_tlast, exp_last);
                end
            end
            prev_stalled = s_axi_tx_tvalid && !s_axi_tx_tready;
            prev_data    = s_axi_tx_tdata;
            prev_last    = s_axi_tx_tlast;
        end
    end

    always @(posedge user_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout: the expected frames did not all arrive in time");
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        user_clk          = 1'b0;
        reset_TX_RX_Block = 1'b1;
        empty             = 1'b1;
        dout              = '0;
        channel_up        = 1'b0;
        s_axi_tx_tready   = 1'b0;
        random_stall      = 1'b0;
        prev_stalled      = 1'b0;
        exp_seq           = '0;   // First frame after reset carries 0
        pop_count         = 0;
        cycle_count       = 0;
        pattern_idx       = 0;
        seed_value        = 32'ha1d4;
        void'($urandom(seed_value));
        for (int i = 0; i < PATTERN_LEN; i++) begin
            ready_pattern[i] = ($urandom % STALL_FACTOR) != 0;
        end
        fill_table();

        repeat (RESET_CYCLES) @(posedge user_clk);
        reset_TX_RX_Block <= 1'b0;
        @(negedge user_clk);
        check_value("rd_en", rd_en, 1'b0);
        check_value("s_axi_tx_tvalid", s_axi_tx_tvalid, 1'b0);
        check_value("s_axi_tx_tlast", s_axi_tx_tlast, 1'b0);

        // Packets wait in the FIFO while the link trains
        for (int i = 0; i < ROWS; i++) begin
            push_row(i);
        end
        @(posedge user_clk);
        channel_up <= 1'b1;   // Three high samples are one short of stable
        repeat (LINK_STABLE_CYCLES - 1) @(posedge user_clk);
        channel_up <= 1'b0;
        repeat (6) @(posedge user_clk);
        channel_up <= 1'b1;
        repeat (2) @(posedge user_clk);
        channel_up <= 1'b0;
        repeat (6) @(posedge user_clk);
        @(negedge user_clk);
        check_value("pop count during training", pop_count, 0);

        @(posedge user_clk);
        channel_up <= 1'b1;   // Link stays up from here on
        wait_for_drain(ROWS);

        // Second pass runs under random back-pressure and the sequence keeps counting
        random_stall = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            push_row(i);
        end
        wait_for_drain(PASSES * ROWS);

        repeat (20) @(negedge user_clk);   // Any stray word or pop hits the checkers
        check_value("s_axi_tx_tvalid", s_axi_tx_tvalid, 1'b0);
        check_value("rd_en", rd_en, 1'b0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: flist.f
rtl/fifo_aurora_pkg.sv
rtl/link_up_filter.sv
rtl/packet_shifter.sv
rtl/tx_frame_ctrl.sv
rtl/stream_out_reg.sv
rtl/fifo_to_aurora_tx.sv
test/tb_fifo_to_aurora_tx.sv

// File: Bender.yml
package:
  name: fifo_to_aurora_tx

sources:
  # Package first, then the leaf modules and the top level
  - files:
      - rtl/fifo_aurora_pkg.sv
      - rtl/link_up_filter.sv
      - rtl/packet_shifter.sv
      - rtl/tx_frame_ctrl.sv
      - rtl/stream_out_reg.sv
      - rtl/fifo_to_aurora_tx.sv

  # Testbench
  - target: test
    files:
      - test/tb_fifo_to_aurora_tx.sv
